/* all.f */
otp_buf_pkg.sv
otp_secded_enc.sv
otp_secded_dec.sv
otp_ecc_reg.sv
otp_part_ctrl.sv
otp_part_buf.sv
tb_otp_part_buf.sv

/* Makefile */
SIM      := verilator
TOP      := tb_otp_part_buf
LINT_TOP := otp_part_buf
FILELIST := all.f
FLAGS    := --binary --timing -Wno-fatal -j 0
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

lint:
	$(SIM) --lint-only -Wall --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_otp_part_buf.sv */
//###########################################################
// Testbench for the buffered OTP partition.
// An OTP macro model answers the read strobes with encoded
// words and optional bit flips. Directed tests check loads.
//###########################################################

module tb_otp_part_buf;

  import otp_buf_pkg::*;

  localparam int ClkPeriod  = 100;
  localparam int LoadCount  = 6;
  localparam int WordCycles = 6;
  localparam int TimeLimit  = (LoadCount * PartDepth * WordCycles + 300) * ClkPeriod;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 init_i;
  logic                 otp_rd_o;
  logic [PartAw-1:0]    otp_addr_o;
  logic                 otp_rvalid_i;
  ecc_word_t            otp_rdata_i;
  logic [PartAw-1:0]    rd_addr_i;
  logic [DataWidth-1:0] rd_data_o;
  logic                 ready_o;
  logic                 err_o;
  err_status_t          status_o;

  // Macro contents, injected flips and the request counter.
  logic [DataWidth-1:0] otp_mem   [PartDepth];
  logic [CodeWidth-1:0] flip_mask [PartDepth];
  int                   req_count;
  integer               seed = 32'h23640fff;

  otp_part_buf uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .init_i       (init_i),
    .otp_rd_o     (otp_rd_o),
    .otp_addr_o   (otp_addr_o),
    .otp_rvalid_i (otp_rvalid_i),
    .otp_rdata_i  (otp_rdata_i),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o),
    .ready_o      (ready_o),
    .err_o        (err_o),
    .status_o     (status_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Places the data in the Hamming positions first, then forms the parities.
  function automatic ecc_word_t encode_word(input logic [DataWidth-1:0] data);
    ecc_word_t   code;
    logic [71:1] cw;
    int          p;
    int          i;
    int          idx;
    cw  = '0;
    idx = 0;
    for (p = 1; p < 72; p++) begin
      if ((p & (p - 1)) != 0) begin
        cw[p] = data[idx];
        idx++;
      end
    end
    code.data = data;
    code.ecc  = '0;
    for (i = 0; i < 7; i++) begin
      for (p = 1; p < 72; p++) begin
        if (p[i]) code.ecc[i] = code.ecc[i] ^ cw[p];
      end
    end
    code.ecc[7] = ^{code.ecc[6:0], data};
    return code;
  endfunction

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
      $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // OTP macro model that sends one reply per strobe after 1 to 4 cycles.
  always begin : macro_model
    int unsigned       delay;
    logic [PartAw-1:0] addr;
    @(posedge clk_i);
    if (otp_rd_o === 1'b1) begin
      check_val(otp_addr_o, req_count % PartDepth, "requested address");
      addr = otp_addr_o;
      req_count++;
      delay = 1 + ({$random(seed)} % 4);
      repeat (delay - 1) begin
        @(posedge clk_i);
        check_val(otp_rd_o, 1'b0, "read strobe while a read is pending");
      end
      otp_rvalid_i <= 1'b1;
      otp_rdata_i  <= encode_word(otp_mem[addr]) ^ flip_mask[addr];
      @(posedge clk_i);
      check_val(otp_rd_o, 1'b0, "read strobe in the reply cycle");
      otp_rvalid_i <= 1'b0;
    end
  end

  task automatic fill_model();
    int a;
    for (a = 0; a < PartDepth; a++) begin
      otp_mem[a]   = {$random(seed), $random(seed)};
      flip_mask[a] = '0;
    end
  endtask

  task automatic pulse_init();
    @(posedge clk_i);
    init_i <= 1'b1;
    @(posedge clk_i);
    init_i <= 1'b0;
  endtask

  task automatic check_image(input logic zero_exp);
    int a;
    for (a = 0; a < PartDepth; a++) begin
      @(posedge clk_i);
      rd_addr_i <= PartAw'(a);
      @(negedge clk_i);
      check_val(rd_data_o, zero_exp ? '0 : otp_mem[a], "buffer read data");
    end
  endtask

  task automatic load_and_check(input logic [2:0] exp_status);
    req_count = 0;
    pulse_init();
    do @(negedge clk_i); while (!ready_o && !err_o);
    check_val(err_o, 1'b0, "error flag after load");
    check_val(req_count, PartDepth, "number of reads");
    check_val(status_o, exp_status, "status after load");
    check_image(1'b0);
  endtask

  task automatic test_reset_values();
    @(negedge clk_i);
    check_val(ready_o, 1'b0, "ready after reset");
    check_val(err_o, 1'b0, "error after reset");
    check_val(otp_rd_o, 1'b0, "read strobe after reset");
    check_val(status_o, 3'b000, "status after reset");
    check_image(1'b1);
  endtask

  task automatic test_clean_load();
    fill_model();
    load_and_check(3'b000);
  endtask

  // New contents with flips in two data bits and in Hamming check bit 6.
  task automatic test_corrected_load();
    fill_model();
    flip_mask[1] = 72'(1) << 7;
    flip_mask[4] = 72'(1) << 70;
    flip_mask[6] = 72'(1) << 33;
    load_and_check(3'b001);
  endtask

  task automatic test_reload();
    fill_model();
    load_and_check(3'b000);
  endtask

  task automatic test_uncorrectable();
    fill_model();
    flip_mask[5] = (72'(1) << 2) | (72'(1) << 40);
    req_count = 0;
    pulse_init();
    do @(negedge clk_i); while (!err_o);
    check_val(ready_o, 1'b0, "ready in error state");
    check_val(status_o, 3'b100, "status after uncorrectable word");
    repeat (10) @(negedge clk_i);
    check_val(req_count, 6, "reads issued up to the bad word");
    check_image(1'b1);
    pulse_init();
    repeat (10) @(negedge clk_i);
    check_val(err_o, 1'b1, "error state after init");
    check_val(req_count, 6, "reads after init in error state");
  endtask

  task automatic test_reset_recovery();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset_values();
    test_clean_load();
  endtask

  initial begin : watchdog
    #(TimeLimit);
    $display("Timeout: the tests did not finish within %0d time units.", TimeLimit);
    $display("Test failed");
    $fatal(1);
  end

  initial begin : main
    rst_ni       = 1'b0;
    init_i       = 1'b0;
    otp_rvalid_i = 1'b0;
    otp_rdata_i  = '0;
    rd_addr_i    = '0;
    req_count    = 0;
    fill_model();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset_values();
    test_clean_load();
    test_corrected_load();
    test_reload();
    test_uncorrectable();
    test_reset_recovery();
    $display("Test passed");
    $finish;
  end

endmodule : tb_otp_part_buf

/* otp_part_buf.sv */
//###########################################################
// Buffered OTP partition.
// Loads the partition image on init and serves reads from
// an ECC protected copy.
//###########################################################

module otp_part_buf (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              init_i,
  output logic                              otp_rd_o,
  output logic [otp_buf_pkg::PartAw-1:0]    otp_addr_o,
  input  logic                              otp_rvalid_i,
  input  otp_buf_pkg::ecc_word_t            otp_rdata_i,
  input  logic [otp_buf_pkg::PartAw-1:0]    rd_addr_i,
  output logic [otp_buf_pkg::DataWidth-1:0] rd_data_o,
  output logic                              ready_o,
  output logic                              err_o,
  output otp_buf_pkg::err_status_t          status_o
);

  import otp_buf_pkg::*;

  logic [DataWidth-1:0] dec_data;
  logic                 dec_single;
  logic                 dec_double;
  logic                 buf_wren;
  logic [PartAw-1:0]    buf_addr;
  logic [DataWidth-1:0] buf_wdata;
  logic                 buf_ecc_err;
  logic [PartAw-1:0]    reg_addr;
  logic [DataWidth-1:0] reg_rdata;

  // Replies from the macro are corrected on the way in.
  otp_secded_dec u_in_dec (
    .code_i       (otp_rdata_i),
    .data_o       (dec_data),
    .single_err_o (dec_single),
    .double_err_o (dec_double)
  );

  otp_part_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .init_i        (init_i),
    .otp_rd_o      (otp_rd_o),
    .otp_addr_o    (otp_addr_o),
    .otp_rvalid_i  (otp_rvalid_i),
    .dec_data_i    (dec_data),
    .dec_single_i  (dec_single),
    .dec_double_i  (dec_double),
    .buf_wren_o    (buf_wren),
    .buf_addr_o    (buf_addr),
    .buf_wdata_o   (buf_wdata),
    .buf_ecc_err_i (buf_ecc_err),
    .ready_o       (ready_o),
    .err_o         (err_o),
    .status_o      (status_o)
  );

  // Loader owns the address until the image is ready.
  assign reg_addr = ready_o ? rd_addr_i : buf_addr;

  otp_ecc_reg u_buf (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wren_i    (buf_wren),
    .addr_i    (reg_addr),
    .wdata_i   (buf_wdata),
    .rdata_o   (reg_rdata),
    .ecc_err_o (buf_ecc_err)
  );

  assign rd_data_o = ready_o ? reg_rdata : '0;

endmodule : otp_part_buf

/* otp_part_ctrl.sv */
//###########################################################
// Partition load controller.
// Reads every word from the OTP macro one at a time, writes
// the corrected data into the buffer and tracks errors.
//###########################################################

module otp_part_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              init_i,
  // OTP macro read side.
  output logic                              otp_rd_o,
  output logic [otp_buf_pkg::PartAw-1:0]    otp_addr_o,
  input  logic                              otp_rvalid_i,
  // Decoded reply.
  input  logic [otp_buf_pkg::DataWidth-1:0] dec_data_i,
  input  logic                              dec_single_i,
  input  logic                              dec_double_i,
  // Buffer write side.
  output logic                              buf_wren_o,
  output logic [otp_buf_pkg::PartAw-1:0]    buf_addr_o,
  output logic [otp_buf_pkg::DataWidth-1:0] buf_wdata_o,
  input  logic                              buf_ecc_err_i,
  // Status.
  output logic                              ready_o,
  output logic                              err_o,
  output otp_buf_pkg::err_status_t          status_o
);

  import otp_buf_pkg::*;

  localparam logic [PartAw-1:0] LastAddr = PartAw'(PartDepth - 1);

  part_state_e        state_d, state_q;
  logic [PartAw-1:0]  addr_d, addr_q;
  err_status_t        status_d, status_q;

  always_comb begin : p_fsm
    state_d    = state_q;
    addr_d     = addr_q;
    status_d   = status_q;
    buf_wren_o = 1'b0;

    case (state_q)
      IDLE: begin
        if (init_i) begin
          state_d  = READ;
          addr_d   = '0;
          status_d = '0;
        end
      end
      // Strobe goes out for one cycle.
      READ: begin
        state_d = WAIT;
      end
      WAIT: begin
        if (otp_rvalid_i) begin
          if (dec_double_i) begin
            // Drop the word and stop reading.
            state_d              = ERROR;
            status_d.load_uncorr = 1'b1;
          end else begin
            buf_wren_o = 1'b1;
            if (dec_single_i) begin
              status_d.corrected = 1'b1;
            end
            if (addr_q == LastAddr) begin
              state_d = READY;
            end else begin
              addr_d  = addr_q + 1'b1;
              state_d = READ;
            end
          end
        end
      end
      READY: begin
        // A stored word going bad wins over a new load.
        if (buf_ecc_err_i) begin
          state_d            = ERROR;
          status_d.store_err = 1'b1;
        end else if (init_i) begin
          state_d  = READ;
          addr_d   = '0;
          status_d = '0;
        end
      end
      ERROR: begin
        state_d = ERROR;
      end
      default: begin
        state_d = ERROR;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q  <= IDLE;
      addr_q   <= '0;
      status_q <= '0;
    end else begin
      state_q  <= state_d;
      addr_q   <= addr_d;
      status_q <= status_d;
    end
  end

  assign otp_rd_o    = (state_q == READ);
  assign otp_addr_o  = addr_q;
  assign buf_addr_o  = addr_q;
  assign buf_wdata_o = dec_data_i;
  assign ready_o     = (state_q == READY);
  assign err_o       = (state_q == ERROR);
  assign status_o    = status_q;

endmodule : otp_part_ctrl

/* otp_ecc_reg.sv */
//###########################################################
// ECC protected register file for the partition image.
// One shared encoder on the write path, one decoder per
// entry that checks the stored words all the time.
//###########################################################

module otp_ecc_reg (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              wren_i,
  input  logic [otp_buf_pkg::PartAw-1:0]    addr_i,
  input  logic [otp_buf_pkg::DataWidth-1:0] wdata_i,
  output logic [otp_buf_pkg::DataWidth-1:0] rdata_o,
  output logic                              ecc_err_o
);

  import otp_buf_pkg::*;

  ecc_word_t                  wcode;
  ecc_word_t [PartDepth-1:0]  mem_q;
  logic      [PartDepth-1:0]  single_err;
  logic      [PartDepth-1:0]  double_err;

  otp_secded_enc u_enc (
    .data_i (wdata_i),
    .code_o (wcode)
  );

  // All zeros is a valid codeword, so the reset image passes the check.
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_mem
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (wren_i) begin
      mem_q[addr_i] <= wcode;
    end
  end

  assign rdata_o = mem_q[addr_i].data;

  // Concurrent check of every entry.
  // Errors are only detected here and the corrected data is not used.
  for (genvar k = 0; k < PartDepth; k++) begin : gen_check
    otp_secded_dec u_dec (
      .code_i       (mem_q[k]),
      .data_o       (),
      .single_err_o (single_err[k]),
      .double_err_o (double_err[k])
    );
  end

  assign ecc_err_o = (|single_err) | (|double_err);

endmodule : otp_ecc_reg

/* otp_secded_dec.sv */
//###########################################################
// 72/64 SECDED decoder.
// Corrects a single flipped bit and flags two flipped bits
// as uncorrectable.
//###########################################################

module otp_secded_dec (
  input  otp_buf_pkg::ecc_word_t            code_i,
  output logic [otp_buf_pkg::DataWidth-1:0] data_o,
  output logic                              single_err_o,
  output logic                              double_err_o
);

  import otp_buf_pkg::*;

  logic [EccWidth-2:0] syndrome;
  logic                parity_odd;

  // A valid codeword has even weight.
  assign parity_odd = ^code_i;

  always_comb begin : p_decode
    int unsigned pos;
    int unsigned idx;
    int unsigned b;
    syndrome = code_i.ecc[EccWidth-2:0];
    idx      = 0;
    for (pos = 1; pos < CodeWidth; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        for (b = 0; b < EccWidth - 1; b++) begin
          if (pos[b]) begin
            syndrome[b] ^= code_i.data[idx];
          end
        end
        idx++;
      end
    end

    // Flip the data bit that the syndrome points at.
    // A check bit position matches no data bit and leaves the data alone.
    data_o = code_i.data;
    idx    = 0;
    for (pos = 1; pos < CodeWidth; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        if (parity_odd && (pos == 32'(syndrome))) begin
          data_o[idx] = ~data_o[idx];
        end
        idx++;
      end
    end
  end

  assign single_err_o = parity_odd;
  assign double_err_o = !parity_odd && (syndrome != '0);

endmodule : otp_secded_dec

/* otp_secded_enc.sv */
//###########################################################
// 72/64 SECDED encoder.
// Hamming check bits over the data, plus an overall parity
// bit so that every codeword has even weight.
//###########################################################

module otp_secded_enc (
  input  logic [otp_buf_pkg::DataWidth-1:0] data_i,
  output otp_buf_pkg::ecc_word_t            code_o
);

  import otp_buf_pkg::*;

  logic [EccWidth-2:0] hamming;

  always_comb begin : p_hamming
    int unsigned pos;
    int unsigned idx;
    int unsigned b;
    hamming = '0;
    idx     = 0;
    // Data bits fill the positions that are not powers of two.
    for (pos = 1; pos < CodeWidth; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        for (b = 0; b < EccWidth - 1; b++) begin
          if (pos[b]) begin
            hamming[b] ^= data_i[idx];
          end
        end
        idx++;
      end
    end
  end

  // Top check bit covers the data and the seven Hamming bits.
  assign code_o.ecc  = {^{hamming, data_i}, hamming};
  assign code_o.data = data_i;

endmodule : otp_secded_enc

/* otp_buf_pkg.sv */
//###########################################################
// OTP buffered partition package.
// Partition geometry, the 72/64 SECDED codeword layout,
// controller state encoding and the error status word.
//###########################################################

package otp_buf_pkg;

  // Partition geometry.
  localparam int PartDepth = 8;
  localparam int PartAw    = $clog2(PartDepth);

  // Codeword geometry.
  localparam int DataWidth = 64;
  localparam int EccWidth  = 8;
  localparam int CodeWidth = DataWidth + EccWidth;

  // Check bits sit above the data bits.
  typedef struct packed {
    logic [EccWidth-1:0]  ecc;
    logic [DataWidth-1:0] data;
  } ecc_word_t;

  // Load sequencer states.
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    READ  = 3'd1,
    WAIT  = 3'd2,
    READY = 3'd3,
    ERROR = 3'd4
  } part_state_e;

  typedef struct packed {
    logic load_uncorr;
    logic store_err;
    logic corrected;
  } err_status_t;

endpackage : otp_buf_pkg
